/* source/ob_pkg.sv */
package ob_pkg;

  // Order and command identifier
  typedef logic [7:0] uid_t;

  // Reserved uid on trade responses, never sent by a client
  localparam uid_t trade_uid = '1;

  // Plain binary price
  typedef logic [15:0] price_t;

  // Share count
  typedef logic [7:0] quantity_t;

  typedef enum logic [2:0] {
    op_nop          = 3'd0,
    op_buy          = 3'd1,
    op_sell         = 3'd2,
    op_qry_bid_ask  = 3'd3,
    op_pop_top_bid  = 3'd4,
    op_pop_top_ask  = 3'd5
  } opcode_t;

  typedef enum logic [1:0] {
    s_okay    = 2'd0,
    s_bad_pop = 2'd1,
    s_reject  = 2'd2
  } status_t;

  // One resting order in a book table
  typedef struct packed {
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } entry_t;

  // Buy and Sell share this operand layout
  typedef struct packed {
    quantity_t quantity;
    price_t    price;
  } operand_t;

  typedef struct packed {
    uid_t     uid;
    opcode_t  opcode;
    operand_t operand;
  } cmd_t;

  // Query result, zero price for an empty side
  typedef struct packed {
    price_t bid_price;
    price_t ask_price;
  } result_qry_t;

  typedef struct packed {
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } result_pop_t;

  // Padded out to the union width
  typedef struct packed {
    uid_t       bid_uid;
    uid_t       ask_uid;
    quantity_t  quantity;
    logic [7:0] pad;
  } result_trade_t;

  // Same 32-bit word, decoded per response kind
  typedef union packed {
    result_qry_t   qry;
    result_pop_t   pop;
    result_trade_t trade;
  } result_u;

  typedef struct packed {
    uid_t    uid;
    status_t status;
    result_u result;
  } rsp_t;

  // Registered trade decision
  typedef struct packed {
    logic      vld;
    logic      bid_consumed;
    logic      ask_consumed;
    uid_t      bid_uid;
    uid_t      ask_uid;
    quantity_t quantity;
    quantity_t remainder;
  } cmp_t;

endpackage

/* source/ob_cmd_latch.sv */
`timescale 1ns/1ps

module ob_cmd_latch (
  input  logic         clk,
  input  logic         rst,
  input  logic         cmd_in_vld,
  input  ob_pkg::cmd_t cmd_in,
  output logic         cmd_in_pop,
  input  logic         consume,
  output logic         cmd_vld,
  output ob_pkg::cmd_t cmd
);

  logic fetch;

  // Refill when empty or when the held command leaves this cycle
  assign fetch      = cmd_in_vld & (consume | ~cmd_vld);
  assign cmd_in_pop = fetch;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_vld <= 1'b0;
    end else if (fetch) begin
      cmd_vld <= 1'b1;
    end else if (consume) begin
      cmd_vld <= 1'b0;
    end
  end

  // Held command, visible from the next cycle
  always_ff @(posedge clk) begin
    if (fetch) begin
      cmd <= cmd_in;
    end
  end

endmodule

/* source/ob_book_table.sv */
`timescale 1ns/1ps

module ob_book_table #(
  parameter int table_depth = 4,
  parameter bit is_bid      = 1'b1
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           insert,
  input  ob_pkg::entry_t insert_entry,
  input  logic           pop,
  input  logic           update_vld,
  input  ob_pkg::entry_t update_entry,
  input  logic           reject_pop,
  output logic           head_vld,
  output ob_pkg::entry_t head,
  output logic           reject_vld,
  output ob_pkg::entry_t reject
);

  import ob_pkg::*;

  localparam int cnt_w = $clog2(table_depth + 1);

  // Slot 0 holds the best price
  entry_t                 slots      [table_depth];
  entry_t                 slots_next [table_depth];
  logic [cnt_w-1:0]       count;
  logic                   full;
  logic                   do_insert;
  // Slot i keeps its place in front of the new order
  logic [table_depth-1:0] ahead;

  assign full      = (count == cnt_w'(table_depth));
  assign do_insert = insert & ~full;
  assign head_vld  = (count != '0);
  // Empty table reads a zero head
  assign head      = head_vld ? slots[0] : '0;

  always_comb begin
    for (int i = 0; i < table_depth; i++) begin
      // Ties stay ahead, so equal prices keep arrival order
      if (is_bid) begin
        ahead[i] = (i < int'(count)) && (insert_entry.price <= slots[i].price);
      end else begin
        ahead[i] = (i < int'(count)) && (insert_entry.price >= slots[i].price);
      end
    end
  end

  always_comb begin
    slots_next = slots;
    if (do_insert) begin
      // New order lands at the first slot not ahead of it
      if (!ahead[0]) begin
        slots_next[0] = insert_entry;
      end
      for (int i = 1; i < table_depth; i++) begin
        if (ahead[i-1] && !ahead[i]) begin
          slots_next[i] = insert_entry;
        end else if (!ahead[i-1]) begin
          // Everything behind moves back by one
          slots_next[i] = slots[i-1];
        end
      end
    end else if (pop) begin
      // Shift toward the head
      for (int i = 0; i < table_depth - 1; i++) begin
        slots_next[i] = slots[i+1];
      end
    end else if (update_vld) begin
      // Partial fill leaves the remainder on the head
      slots_next[0].quantity = update_entry.quantity;
    end
  end

  always_ff @(posedge clk) begin
    slots <= slots_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      reject_vld <= 1'b0;
    end else begin
      if (do_insert) begin
        count <= count + 1'b1;
      end else if (pop) begin
        count <= count - 1'b1;
      end
      // Full table parks the order for a reject response
      if (insert && full) begin
        reject_vld <= 1'b1;
      end else if (reject_pop) begin
        reject_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (insert && full) begin
      reject <= insert_entry;
    end
  end

endmodule

/* source/ob_trade_cmp.sv */
`timescale 1ns/1ps

module ob_trade_cmp (
  input  logic           clk,
  input  logic           rst,
  input  logic           bid_vld,
  input  ob_pkg::entry_t bid,
  input  logic           ask_vld,
  input  ob_pkg::entry_t ask,
  input  logic           sample,
  output ob_pkg::cmp_t   result
);

  import ob_pkg::*;

  cmp_t next_result;
  logic can_trade;

  // Both heads present and the bid reaches the ask
  assign can_trade = bid_vld & ask_vld & (bid.price >= ask.price);

  always_comb begin
    next_result         = '0;
    next_result.bid_uid = bid.uid;
    next_result.ask_uid = ask.uid;
    if (can_trade) begin
      next_result.vld = 1'b1;
      if (bid.quantity < ask.quantity) begin
        // Bid fills completely, ask keeps the rest
        next_result.bid_consumed = 1'b1;
        next_result.quantity     = bid.quantity;
        next_result.remainder    = ask.quantity - bid.quantity;
      end else if (ask.quantity < bid.quantity) begin
        next_result.ask_consumed = 1'b1;
        next_result.quantity     = ask.quantity;
        next_result.remainder    = bid.quantity - ask.quantity;
      end else begin
        // Exact match, both heads leave
        next_result.bid_consumed = 1'b1;
        next_result.ask_consumed = 1'b1;
        next_result.quantity     = bid.quantity;
      end
    end
  end

  // Registered so the subtract stays off the controller path
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (sample) begin
      result <= next_result;
    end
  end

endmodule

/* source/ob_cntrl_fsm.sv */
`timescale 1ns/1ps

module ob_cntrl_fsm (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_vld,
  input  ob_pkg::cmd_t   cmd,
  output logic           consume,
  input  logic           rsp_out_full,
  output logic           rsp_out_vld,
  output ob_pkg::rsp_t   rsp_out,
  output logic           cmp_sample,
  input  ob_pkg::cmp_t   cmp_result,
  input  logic           bid_head_vld,
  input  ob_pkg::entry_t bid_head,
  input  logic           bid_reject_vld,
  input  ob_pkg::entry_t bid_reject,
  output logic           bid_insert,
  output ob_pkg::entry_t bid_insert_entry,
  output logic           bid_pop,
  output logic           bid_update_vld,
  output ob_pkg::entry_t bid_update_entry,
  output logic           bid_reject_pop,
  input  logic           ask_head_vld,
  input  ob_pkg::entry_t ask_head,
  input  logic           ask_reject_vld,
  input  ob_pkg::entry_t ask_reject,
  output logic           ask_insert,
  output ob_pkg::entry_t ask_insert_entry,
  output logic           ask_pop,
  output logic           ask_update_vld,
  output ob_pkg::entry_t ask_update_entry,
  output logic           ask_reject_pop
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue_qry,
    st_execute
  } state_t;

  state_t state;
  state_t state_next;
  entry_t new_entry;

  // Order built from the held Buy or Sell
  assign new_entry = '{uid: cmd.uid, quantity: cmd.operand.quantity,
                       price: cmd.operand.price};

  always_comb begin
    result_u res;
    entry_t  upd;
    state_next       = state;
    consume          = 1'b0;
    rsp_out_vld      = 1'b0;
    rsp_out          = '0;
    cmp_sample       = 1'b0;
    bid_insert       = 1'b0;
    bid_insert_entry = new_entry;
    bid_pop          = 1'b0;
    bid_update_vld   = 1'b0;
    bid_update_entry = '0;
    bid_reject_pop   = 1'b0;
    ask_insert       = 1'b0;
    ask_insert_entry = new_entry;
    ask_pop          = 1'b0;
    ask_update_vld   = 1'b0;
    ask_update_entry = '0;
    ask_reject_pop   = 1'b0;
    res              = '0;
    upd              = '0;
    rsp_out.status   = s_okay;

    // Full egress freezes everything
    if (!rsp_out_full) begin
      case (state)
        st_idle: begin
          if (cmd_vld) begin
            consume     = 1'b1;
            rsp_out.uid = cmd.uid;
            case (cmd.opcode)
              op_nop: rsp_out_vld = 1'b1;
              op_qry_bid_ask: begin
                rsp_out_vld       = 1'b1;
                res.qry.bid_price = bid_head.price;
                res.qry.ask_price = ask_head.price;
              end
              op_buy: begin
                rsp_out_vld = 1'b1;
                bid_insert  = 1'b1;
                state_next  = st_issue_qry;
              end
              op_sell: begin
                rsp_out_vld = 1'b1;
                ask_insert  = 1'b1;
                state_next  = st_issue_qry;
              end
              op_pop_top_bid: begin
                rsp_out_vld      = 1'b1;
                bid_pop          = bid_head_vld;
                rsp_out.status   = bid_head_vld ? s_okay : s_bad_pop;
                res.pop.uid      = bid_head.uid;
                res.pop.quantity = bid_head.quantity;
                res.pop.price    = bid_head.price;
              end
              op_pop_top_ask: begin
                rsp_out_vld      = 1'b1;
                ask_pop          = ask_head_vld;
                rsp_out.status   = ask_head_vld ? s_okay : s_bad_pop;
                res.pop.uid      = ask_head.uid;
                res.pop.quantity = ask_head.quantity;
                res.pop.price    = ask_head.price;
              end
              // Unknown opcode dropped silently
              default: ;
            endcase
          end
        end
        st_issue_qry: begin
          // Heads now reflect the last table change
          cmp_sample = 1'b1;
          state_next = st_execute;
        end
        st_execute: begin
          if (cmp_result.vld) begin
            rsp_out_vld           = 1'b1;
            rsp_out.uid           = trade_uid;
            res.trade.bid_uid     = cmp_result.bid_uid;
            res.trade.ask_uid     = cmp_result.ask_uid;
            res.trade.quantity    = cmp_result.quantity;
            bid_pop               = cmp_result.bid_consumed;
            ask_pop               = cmp_result.ask_consumed;
            // Survivor head keeps the remainder
            if (cmp_result.bid_consumed && !cmp_result.ask_consumed) begin
              upd              = ask_head;
              upd.quantity     = cmp_result.remainder;
              ask_update_vld   = 1'b1;
              ask_update_entry = upd;
            end else if (cmp_result.ask_consumed && !cmp_result.bid_consumed) begin
              upd              = bid_head;
              upd.quantity     = cmp_result.remainder;
              bid_update_vld   = 1'b1;
              bid_update_entry = upd;
            end
            // Try again on the new heads
            state_next = st_issue_qry;
          end else if (bid_reject_vld) begin
            rsp_out_vld    = 1'b1;
            rsp_out.uid    = bid_reject.uid;
            rsp_out.status = s_reject;
            bid_reject_pop = 1'b1;
          end else if (ask_reject_vld) begin
            rsp_out_vld    = 1'b1;
            rsp_out.uid    = ask_reject.uid;
            rsp_out.status = s_reject;
            ask_reject_pop = 1'b1;
          end else begin
            // Book is quiet again
            state_next = st_idle;
          end
        end
        default: state_next = st_idle;
      endcase
    end

    rsp_out.result = res;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* source/ob_engine.sv */
`timescale 1ns/1ps

module ob_engine #(
  parameter int table_depth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         cmd_in_vld,
  input  ob_pkg::cmd_t cmd_in,
  output logic         cmd_in_pop,
  input  logic         rsp_out_full,
  output logic         rsp_out_vld,
  output ob_pkg::rsp_t rsp_out
);

  import ob_pkg::*;

  // Latch to controller
  logic   cmd_vld;
  cmd_t   cmd;
  logic   consume;

  // Comparator
  logic   cmp_sample;
  cmp_t   cmp_result;

  // Bid side
  logic   bid_head_vld;
  entry_t bid_head;
  logic   bid_reject_vld;
  entry_t bid_reject;
  logic   bid_insert;
  entry_t bid_insert_entry;
  logic   bid_pop;
  logic   bid_update_vld;
  entry_t bid_update_entry;
  logic   bid_reject_pop;

  // Ask side
  logic   ask_head_vld;
  entry_t ask_head;
  logic   ask_reject_vld;
  entry_t ask_reject;
  logic   ask_insert;
  entry_t ask_insert_entry;
  logic   ask_pop;
  logic   ask_update_vld;
  entry_t ask_update_entry;
  logic   ask_reject_pop;

  ob_cmd_latch i_cmd_latch (
    .clk        (clk),
    .rst        (rst),
    .cmd_in_vld (cmd_in_vld),
    .cmd_in     (cmd_in),
    .cmd_in_pop (cmd_in_pop),
    .consume    (consume),
    .cmd_vld    (cmd_vld),
    .cmd        (cmd)
  );

  // Bids sorted highest first
  ob_book_table #(
    .table_depth (table_depth),
    .is_bid      (1'b1)
  ) i_bid_table (
    .clk          (clk),
    .rst          (rst),
    .insert       (bid_insert),
    .insert_entry (bid_insert_entry),
    .pop          (bid_pop),
    .update_vld   (bid_update_vld),
    .update_entry (bid_update_entry),
    .reject_pop   (bid_reject_pop),
    .head_vld     (bid_head_vld),
    .head         (bid_head),
    .reject_vld   (bid_reject_vld),
    .reject       (bid_reject)
  );

  // Asks sorted lowest first
  ob_book_table #(
    .table_depth (table_depth),
    .is_bid      (1'b0)
  ) i_ask_table (
    .clk          (clk),
    .rst          (rst),
    .insert       (ask_insert),
    .insert_entry (ask_insert_entry),
    .pop          (ask_pop),
    .update_vld   (ask_update_vld),
    .update_entry (ask_update_entry),
    .reject_pop   (ask_reject_pop),
    .head_vld     (ask_head_vld),
    .head         (ask_head),
    .reject_vld   (ask_reject_vld),
    .reject       (ask_reject)
  );

  ob_trade_cmp i_trade_cmp (
    .clk     (clk),
    .rst     (rst),
    .bid_vld (bid_head_vld),
    .bid     (bid_head),
    .ask_vld (ask_head_vld),
    .ask     (ask_head),
    .sample  (cmp_sample),
    .result  (cmp_result)
  );

  ob_cntrl_fsm i_cntrl_fsm (
    .clk              (clk),
    .rst              (rst),
    .cmd_vld          (cmd_vld),
    .cmd              (cmd),
    .consume          (consume),
    .rsp_out_full     (rsp_out_full),
    .rsp_out_vld      (rsp_out_vld),
    .rsp_out          (rsp_out),
    .cmp_sample       (cmp_sample),
    .cmp_result       (cmp_result),
    .bid_head_vld     (bid_head_vld),
    .bid_head         (bid_head),
    .bid_reject_vld   (bid_reject_vld),
    .bid_reject       (bid_reject),
    .bid_insert       (bid_insert),
    .bid_insert_entry (bid_insert_entry),
    .bid_pop          (bid_pop),
    .bid_update_vld   (bid_update_vld),
    .bid_update_entry (bid_update_entry),
    .bid_reject_pop   (bid_reject_pop),
    .ask_head_vld     (ask_head_vld),
    .ask_head         (ask_head),
    .ask_reject_vld   (ask_reject_vld),
    .ask_reject       (ask_reject),
    .ask_insert       (ask_insert),
    .ask_insert_entry (ask_insert_entry),
    .ask_pop          (ask_pop),
    .ask_update_vld   (ask_update_vld),
    .ask_update_entry (ask_update_entry),
    .ask_reject_pop   (ask_reject_pop)
  );

endmodule

/* verif/ob_chk.sv */
`timescale 1ns/1ps

module ob_chk (
  input logic clk,
  input logic rst,
  input logic cmd_in_vld,
  input logic cmd_in_pop,
  input logic rsp_out_full,
  input logic rsp_out_vld,
  input logic bid_pop,
  input logic bid_update_vld,
  input logic ask_pop,
  input logic ask_update_vld
);

  // Egress full freezes the response stream
  a_no_rsp_while_full: assert property (
    @(posedge clk) disable iff (rst) rsp_out_full |-> !rsp_out_vld
  ) else $error("response emitted while rsp_out_full was high");

  // Ingress pop only on a presented command
  a_pop_needs_vld: assert property (
    @(posedge clk) disable iff (rst) cmd_in_pop |-> cmd_in_vld
  ) else $error("cmd_in_pop without cmd_in_vld");

  // Consumed head leaves, survivor head is rewritten, never both
  a_bid_pop_or_update: assert property (
    @(posedge clk) disable iff (rst) !(bid_pop && bid_update_vld)
  ) else $error("bid table got pop and update together");

  a_ask_pop_or_update: assert property (
    @(posedge clk) disable iff (rst) !(ask_pop && ask_update_vld)
  ) else $error("ask table got pop and update together");

endmodule

bind ob_engine ob_chk i_chk (
  .clk            (clk),
  .rst            (rst),
  .cmd_in_vld     (cmd_in_vld),
  .cmd_in_pop     (cmd_in_pop),
  .rsp_out_full   (rsp_out_full),
  .rsp_out_vld    (rsp_out_vld),
  .bid_pop        (bid_pop),
  .bid_update_vld (bid_update_vld),
  .ask_pop        (ask_pop),
  .ask_update_vld (ask_update_vld)
);

/* verif/ob_tb.sv */
`timescale 1ns/1ps

module ob_tb;

  import ob_pkg::*;

  localparam int depth        = 4;
  localparam int pop_timeout  = 500;
  localparam int drain_limit  = 2000;
  localparam int random_cmds  = 200;

  logic clk;
  logic rst;
  logic cmd_in_vld;
  cmd_t cmd_in;
  logic cmd_in_pop;
  logic rsp_out_full;
  logic rsp_out_vld;
  rsp_t rsp_out;

  // Stimulus state
  logic   random_full;
  uid_t   next_uid;

  // Reference books kept best first and the expected response stream
  entry_t bid_book[$];
  entry_t ask_book[$];
  rsp_t   exp_q[$];

  ob_engine #(
    .table_depth (depth)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .cmd_in_vld   (cmd_in_vld),
    .cmd_in       (cmd_in),
    .cmd_in_pop   (cmd_in_pop),
    .rsp_out_full (rsp_out_full),
    .rsp_out_vld  (rsp_out_vld),
    .rsp_out      (rsp_out)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("response status differs from the model");
    end
  endtask

  task automatic check_rsp(input rsp_t got, input rsp_t exp);
    if (got.uid !== exp.uid) begin
      $display("MISMATCH rsp_out.uid got 0x%h expected 0x%h", got.uid, exp.uid);
      abort_run("response uid differs from the model");
    end
    check_status("rsp_out.status", got.status, exp.status);
    if (got.result !== exp.result) begin
      $display("MISMATCH rsp_out.result got 0x%h expected 0x%h", got.result, exp.result);
      abort_run("response result differs from the model");
    end
  endtask

  // Landing index of a new order behind any equal prices
  function automatic int find_slot(input entry_t book[$], input price_t price, input bit is_bid);
    int pos;
    pos = 0;
    while (pos < book.size() &&
           (is_bid ? (price <= book[pos].price) : (price >= book[pos].price))) begin
      pos++;
    end
    return pos;
  endfunction

  // Appends every response that one command produces
  function automatic void model_cmd(input cmd_t c);
    rsp_t      r;
    entry_t    e;
    entry_t    b;
    entry_t    a;
    logic      rejected;
    quantity_t q;
    r        = '0;
    r.uid    = c.uid;
    r.status = s_okay;
    e        = '{uid: c.uid, quantity: c.operand.quantity, price: c.operand.price};
    rejected = 1'b0;
    case (c.opcode)
      op_qry_bid_ask: begin
        // Empty side reads price zero
        if (bid_book.size() > 0) r.result.qry.bid_price = bid_book[0].price;
        if (ask_book.size() > 0) r.result.qry.ask_price = ask_book[0].price;
      end
      op_pop_top_bid, op_pop_top_ask: begin
        if ((c.opcode == op_pop_top_bid) ? (bid_book.size() == 0) : (ask_book.size() == 0)) begin
          r.status = s_bad_pop;
        end else begin
          b = (c.opcode == op_pop_top_bid) ? bid_book.pop_front() : ask_book.pop_front();
          r.result.pop.uid      = b.uid;
          r.result.pop.quantity = b.quantity;
          r.result.pop.price    = b.price;
        end
      end
      op_buy: begin
        if (bid_book.size() == depth) rejected = 1'b1;
        else bid_book.insert(find_slot(bid_book, e.price, 1'b1), e);
      end
      op_sell: begin
        if (ask_book.size() == depth) rejected = 1'b1;
        else ask_book.insert(find_slot(ask_book, e.price, 1'b0), e);
      end
      default: ;
    endcase
    exp_q.push_back(r);
    if (c.opcode == op_buy || c.opcode == op_sell) begin
      // Match while the book is crossed
      while (bid_book.size() > 0 && ask_book.size() > 0 &&
             bid_book[0].price >= ask_book[0].price) begin
        b = bid_book[0];
        a = ask_book[0];
        q = (b.quantity < a.quantity) ? b.quantity : a.quantity;
        r = '0;
        r.uid                    = trade_uid;
        r.status                 = s_okay;
        r.result.trade.bid_uid   = b.uid;
        r.result.trade.ask_uid   = a.uid;
        r.result.trade.quantity  = q;
        exp_q.push_back(r);
        if (b.quantity == q) void'(bid_book.pop_front());
        else begin
          b.quantity  = b.quantity - q;
          bid_book[0] = b;
        end
        if (a.quantity == q) void'(ask_book.pop_front());
        else begin
          a.quantity  = a.quantity - q;
          ask_book[0] = a;
        end
      end
      // Reject comes after the trades
      if (rejected) begin
        r        = '0;
        r.uid    = c.uid;
        r.status = s_reject;
        exp_q.push_back(r);
      end
    end
  endfunction

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst && rsp_out_vld) begin
      if (exp_q.size() == 0) begin
        abort_run("DUT emitted a response the model did not expect");
      end else begin
        check_rsp(rsp_out, exp_q.pop_front());
      end
    end
  end

  // Egress back pressure
  always @(posedge clk) begin
    #1;
    rsp_out_full = random_full ? (($urandom % 4) == 0) : 1'b0;
  end

  // Leaves cmd_in_vld high for the next send or a release
  task automatic send_cmd(input opcode_t op, input int price, input int qty);
    cmd_t c;
    int   waited;
    c.uid              = next_uid;
    c.opcode           = op;
    c.operand.price    = price_t'(price);
    c.operand.quantity = quantity_t'(qty);
    if (c.uid == trade_uid) abort_run("ran out of command uids");
    next_uid = next_uid + 8'd1;
    @(posedge clk);
    #1;
    cmd_in_vld = 1'b1;
    cmd_in     = c;
    waited     = 0;
    @(negedge clk);
    while (!cmd_in_pop) begin
      waited++;
      if (waited > pop_timeout) abort_run("command was not accepted in time");
      @(negedge clk);
    end
    model_cmd(c);
  endtask

  task automatic release_cmd();
    @(posedge clk);
    #1;
    cmd_in_vld = 1'b0;
    cmd_in     = '0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > drain_limit) abort_run("expected responses never arrived");
      @(negedge clk);
    end
  endtask

  initial begin
    int      sel;
    opcode_t op;
    void'($urandom(32'h5d58));
    rst          = 1'b1;
    cmd_in_vld   = 1'b0;
    cmd_in       = '0;
    rsp_out_full = 1'b0;
    random_full  = 1'b0;
    next_uid     = 8'd1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Plain answers and bad pops on an empty book
    send_cmd(op_qry_bid_ask, 0, 0);
    send_cmd(op_nop, 0, 0);
    send_cmd(op_pop_top_bid, 0, 0);
    send_cmd(op_pop_top_ask, 0, 0);
    // Bids with a tie at 101
    send_cmd(op_buy, 100, 5);
    send_cmd(op_buy, 102, 3);
    send_cmd(op_buy, 101, 4);
    send_cmd(op_buy, 101, 2);
    send_cmd(op_qry_bid_ask, 0, 0);
    // Sweeps all four bids and leaves 2 at 100
    send_cmd(op_sell, 99, 12);
    send_cmd(op_pop_top_bid, 0, 0);
    send_cmd(op_pop_top_bid, 0, 0);
    // Fifth sell bounces off a full ask side
    for (int k = 0; k < 5; k++) begin
      send_cmd(op_sell, 200 + k, 1);
    end
    send_cmd(op_qry_bid_ask, 0, 0);
    for (int k = 0; k < 5; k++) begin
      send_cmd(op_pop_top_ask, 0, 0);
    end
    release_cmd();
    wait_drained();

    // Random mix in a narrow price band
    random_full = 1'b1;
    for (int n = 0; n < random_cmds; n++) begin
      sel = int'($urandom % 16);
      if (sel == 0) op = op_nop;
      else if (sel == 1) op = op_qry_bid_ask;
      else if (sel < 8) op = op_buy;
      else if (sel < 14) op = op_sell;
      else if (sel == 14) op = op_pop_top_bid;
      else op = op_pop_top_ask;
      send_cmd(op, 100 + int'($urandom % 8), 1 + int'($urandom % 8));
      // Occasional idle cycle on the ingress side
      if (($urandom % 5) == 0) release_cmd();
    end
    release_cmd();
    random_full = 1'b0;
    send_cmd(op_qry_bid_ask, 0, 0);
    release_cmd();
    wait_drained();
    // Quiet tail catches any late extra response
    repeat (20) @(negedge clk);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* build.f */
source/ob_pkg.sv
source/ob_cmd_latch.sv
source/ob_book_table.sv
source/ob_trade_cmp.sv
source/ob_cntrl_fsm.sv
source/ob_engine.sv
verif/ob_chk.sv
verif/ob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ob_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
